// File: Bender.yml
package:
  name: pe_simd

dependencies: {}

sources:
  # shared package first
  - common/pe_pkg.sv
  # rtl
  - pe_control/pe_control.sv
  - verilog/dsp_lane.sv
  - verilog/pe_top.sv
  # testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/pe_tb.sv

// File: common/pe_pkg.sv
`default_nettype none

package pe_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int lane_width = 8;                      // bits per lane
    localparam int num_lanes  = 4;
    localparam int word_width = lane_width * num_lanes; // accumulator and operand word
    localparam int inst_width = 64;
    localparam int op_width   = 3;
    localparam int wb_delay   = 6;                      // strobe to write-back valid

    typedef logic [lane_width-1:0] lane_t;
    typedef logic [word_width-1:0] word_t;
    typedef logic [op_width-1:0]   opcode_t;

    ////////////////////
    // opcodes
    ////////////////////
    // msb set marks the immediate form
    localparam opcode_t op_load = 3'b000; // unlisted codes decode as load too
    localparam opcode_t op_add  = 3'b001;
    localparam opcode_t op_sub  = 3'b010;
    localparam opcode_t op_mul  = 3'b011;
    localparam opcode_t op_addi = 3'b101;
    localparam opcode_t op_subi = 3'b110;
    localparam opcode_t op_muli = 3'b111;

    ////////////////////
    // slice settings
    ////////////////////
    localparam logic [3:0] alumode_add   = 4'b0000;
    localparam logic [3:0] alumode_sub   = 4'b0011;   // z - (x + y) style subtract
    localparam logic [4:0] inmode_a2b2   = 5'b00000;
    localparam logic [4:0] inmode_a1b1   = 5'b10001;  // multiplier fed from A1/B1
    localparam logic [6:0] opmode_idle   = 7'b0000000; // lane passes A through
    localparam logic [6:0] opmode_addsub = 7'b0110011;
    localparam logic [6:0] opmode_mul    = 7'b0000101;

    typedef struct packed {
        logic [3:0] alumode;
        logic [4:0] inmode;
        logic [6:0] opmode;
        logic       cea2;    // A2 clock enable
        logic       ceb2;    // B2 clock enable
        logic       usemult; // M register enable
    } slice_cfg_t;

    typedef slice_cfg_t [num_lanes-1:0] slice_cfg_vec_t; // one entry per lane

    // per-opcode lane settings
    localparam slice_cfg_t cfg_load = '{alumode: alumode_add, inmode: inmode_a2b2,
                                        opmode: opmode_idle, cea2: 1'b0, ceb2: 1'b0,
                                        usemult: 1'b0};
    localparam slice_cfg_t cfg_add  = '{alumode: alumode_add, inmode: inmode_a2b2,
                                        opmode: opmode_addsub, cea2: 1'b1, ceb2: 1'b1,
                                        usemult: 1'b0};
    localparam slice_cfg_t cfg_sub  = '{alumode: alumode_sub, inmode: inmode_a2b2,
                                        opmode: opmode_addsub, cea2: 1'b1, ceb2: 1'b1,
                                        usemult: 1'b0};
    localparam slice_cfg_t cfg_mul  = '{alumode: alumode_add, inmode: inmode_a1b1,
                                        opmode: opmode_mul, cea2: 1'b0, ceb2: 1'b0,
                                        usemult: 1'b1};

    ////////////////////
    // instruction word
    ////////////////////
    typedef struct packed {
        word_t                                     operand; // 63:32
        opcode_t                                   opcode;  // 31:29
        logic [inst_width-word_width-op_width-1:0] unused;
    } pe_reg_view_t;

    typedef struct packed {
        word_t                                                unused_hi;
        opcode_t                                              opcode; // 31:29
        logic [inst_width-word_width-op_width-lane_width-1:0] unused_lo;
        lane_t                                                imm;    // broadcast byte
    } pe_imm_view_t;

    // same 64 bits, register or immediate reading
    typedef union packed {
        pe_reg_view_t reg_view;
        pe_imm_view_t imm_view;
    } pe_inst_u;

endpackage

`default_nettype wire

// File: pe_control/pe_control.sv
`timescale 1ns/10ps
`default_nettype none

module pe_control
    import pe_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           inst_v,   // one instruction per strobe
    input  pe_inst_u       inst,
    input  logic           din_ld_v, // external load strobe
    input  word_t          din_ld,
    input  word_t          din_wb,   // lane results, valid with dout_v
    output slice_cfg_vec_t cfg,      // same settings to every lane
    output word_t          dout,     // accumulator
    output logic           dout_v
);

    ////////////////////
    // opcode register
    ////////////////////

    opcode_t    opcode_q;
    slice_cfg_t lane_cfg; // decoded, before the cfg register

    // idle cycles look like a load so the lanes just pass A
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opcode_q <= op_load;
        end else if (inst_v) begin
            opcode_q <= inst.reg_view.opcode; // both views share 31:29
        end else begin
            opcode_q <= op_load;
        end
    end

    ////////////////////
    // decode table
    ////////////////////

    // immediate forms need the same slice setup as the register forms,
    // operand B selection happens in the top
    always_comb begin
        case (opcode_q)
            op_add,
            op_addi: begin
                lane_cfg = cfg_add;
            end
            op_sub,
            op_subi: begin
                lane_cfg = cfg_sub;
            end
            op_mul,
            op_muli: begin
                lane_cfg = cfg_mul;   // A1/B1 into M, A2/B2 left alone
            end
            default: begin
                lane_cfg = cfg_load;  // op_load and the spare code
            end
        endcase
    end

    // cfg valid one edge after the opcode register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < num_lanes; i++) begin
                cfg[i] <= cfg_load;
            end
        end else begin
            for (int i = 0; i < num_lanes; i++) begin
                cfg[i] <= lane_cfg; // no per-lane modes yet
            end
        end
    end

    ////////////////////
    // write-back valid
    ////////////////////

    logic [wb_delay-1:0] wb_sr_q; // one bit per instruction in flight

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_sr_q <= '0;
        end else begin
            wb_sr_q <= {wb_sr_q[wb_delay-2:0], inst_v};
        end
    end

    // lines up with the lane output register
    assign dout_v = wb_sr_q[wb_delay-1];

    ////////////////////
    // accumulator
    ////////////////////

    // write-back beats a load in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout <= '0;
        end else if (dout_v) begin
            dout <= din_wb;      // result of the oldest instruction
        end else if (din_ld_v) begin
            dout <= din_ld;      // external load
        end
    end

    // no interlock here
    // an instruction reads dout as it stands at issue,
    // later write-backs simply overwrite it in order

endmodule

`default_nettype wire

// File: sim.f
+incdir+test
common/pe_pkg.sv
pe_control/pe_control.sv
verilog/dsp_lane.sv
verilog/pe_top.sv
test/pe_tb.sv

// File: test/pe_ref_model.svh
`ifndef pe_ref_model_svh
`define pe_ref_model_svh

////////////////////
// reference model
////////////////////

// expected accumulator after one instruction, lane by lane
// acc is the accumulator value at issue
function automatic word_t pe_ref(input word_t acc, input pe_inst_u ins);
    opcode_t op;
    word_t   opnd;   // operand B word after broadcast
    word_t   res;
    lane_t   a_l;
    lane_t   b_l;
    lane_t   r_l;    // 8 bits wide, so every op wraps mod 256
    int      i;
    op = ins.reg_view.opcode;
    if (op[2]) begin
        opnd = {num_lanes{ins.imm_view.imm}}; // immediate byte to all lanes
    end else begin
        opnd = ins.reg_view.operand;
    end
    for (i = 0; i < num_lanes; i++) begin
        a_l = acc[i*lane_width +: lane_width];
        b_l = opnd[i*lane_width +: lane_width];
        case (op)
            op_add, op_addi: r_l = a_l + b_l;
            op_sub, op_subi: r_l = a_l - b_l;
            op_mul, op_muli: r_l = a_l * b_l; // low byte of the product
            default:         r_l = a_l;       // load and spare code keep A
        endcase
        res[i*lane_width +: lane_width] = r_l;
    end
    return res;
endfunction

`endif

// File: test/pe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pe_tb
    import pe_pkg::*;
();

    logic     clk;
    logic     arst_n;
    logic     inst_v;
    pe_inst_u inst;
    logic     din_ld_v;
    word_t    din_ld;
    word_t    dout;
    logic     dout_v;

    int    seed = 27;
    int    cyc = 0;         // rising edges seen by the compare process
    word_t model_acc = '0;  // accumulator as the model sees it
    word_t last_exp;
    word_t exp_q[$];        // expected write-backs in issue order
    int    due_q[$];        // edge on which each dout_v is due

    pe_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_v   (inst_v),
        .inst     (inst),
        .din_ld_v (din_ld_v),
        .din_ld   (din_ld),
        .dout     (dout),
        .dout_v   (dout_v)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // check helpers
    ////////////////////

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            report_failure("value check failed");
        end
    endtask

    ////////////////////
    // stimulus helpers
    ////////////////////

    function automatic pe_inst_u make_inst(input opcode_t op, input word_t opnd, input lane_t imm);
        pe_inst_u i;
        i = '0;
        i.reg_view.operand = opnd;
        i.reg_view.opcode  = op;
        i.imm_view.imm     = imm; // shares bits 7:0 with the unused field
        return i;
    endfunction

    // junk in every unused bit for the decoder to ignore
    function automatic pe_inst_u random_inst(input opcode_t op);
        pe_inst_u i;
        i = {$random(seed), $random(seed)};
        i.reg_view.opcode = op;
        return i;
    endfunction

    // runs from one falling edge to the next
    task automatic load_word(input word_t w);
        din_ld_v = 1'b1;
        din_ld   = w;
        @(negedge clk);
        din_ld_v = 1'b0;
    endtask

    task automatic issue_inst(input pe_inst_u ins);
        inst_v   = 1'b1;
        inst     = ins;
        last_exp = pe_ref(model_acc, ins); // uses the accumulator at issue
        exp_q.push_back(last_exp);
        due_q.push_back(cyc + 1 + wb_delay);
        @(negedge clk);
        inst_v = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > 4 * wb_delay) report_failure("write-back never arrived, pipeline stuck");
        end
    endtask

    // stop on the falling edge just before the oldest write-back
    task automatic wait_wb_edge();
        int n;
        n = 0;
        if (due_q.size() == 0) report_failure("no instruction in flight to wait for");
        while (cyc + 1 != due_q[0]) begin
            @(negedge clk);
            n++;
            if (n > 2 * wb_delay) report_failure("write-back edge was never reached");
        end
    endtask

    ////////////////////
    // compare process
    ////////////////////

    initial begin : compare_proc
        logic wb_due;
        @(negedge clk);  // reset may still be settling on the first edge
        forever begin
            @(posedge clk);
            cyc    = cyc + 1;
            wb_due = (due_q.size() != 0) && (due_q[0] == cyc);
            check_val("dout_v", dout_v, wb_due);   // exact six-cycle latency
            if (!arst_n) begin
                model_acc = '0;
            end else if (wb_due) begin
                model_acc = exp_q.pop_front();     // write-back beats load
                void'(due_q.pop_front());
            end else if (din_ld_v) begin
                model_acc = din_ld;
            end
            @(negedge clk);
            check_val("dout", dout, model_acc);
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial begin : stim_proc
        word_t   w;
        word_t   tmp;
        opcode_t op;
        arst_n   = 1'b0;
        inst_v   = 1'b0;
        inst     = '0;
        din_ld_v = 1'b0;
        din_ld   = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // idle after reset
        check_val("dout after reset", dout, '0);
        repeat (3) @(negedge clk);

        // plain load
        w = $random(seed);
        load_word(w);
        check_val("dout after load", dout, w);
        repeat (2) @(negedge clk);

        // directed wrap cases in register form
        load_word(32'hff80_7f01);
        issue_inst(make_inst(op_add, 32'h0180_81ff, 8'h00));
        wait_drain();
        check_val("add wrap", dout, last_exp);
        load_word(32'h0010_7f01);
        issue_inst(make_inst(op_sub, 32'h0120_8002, 8'h00));
        wait_drain();
        check_val("sub wrap", dout, last_exp);
        load_word(32'h10ff_0203);
        issue_inst(make_inst(op_mul, 32'h10ff_8055, 8'h00));
        wait_drain();
        check_val("mul wrap", dout, last_exp);

        // random register and immediate forms one at a time
        for (int k = 0; k < 6; k++) begin
            op = opcode_t'(k % 3 + 1) | ((k >= 3) ? 3'b100 : 3'b000);
            for (int r = 0; r < 4; r++) begin
                load_word($random(seed));
                issue_inst(random_inst(op));
                wait_drain();
                check_val("single op result", dout, last_exp);
            end
        end

        // back to back over every opcode
        for (int r = 0; r < 40; r++) begin
            tmp = $random(seed);
            issue_inst(random_inst(tmp[2:0]));
        end
        wait_drain();

        // load in the write-back cycle loses
        load_word($random(seed));
        issue_inst(random_inst(op_add));
        wait_wb_edge();
        load_word($random(seed));
        check_val("wb over load", dout, last_exp);

        // load opcode rewrites the value seen at issue
        w = $random(seed);
        load_word(w);
        issue_inst(random_inst(op_load));
        @(negedge clk);
        load_word($random(seed));
        wait_drain();
        check_val("load opcode", dout, w);

        repeat (2) @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

    `include "pe_ref_model.svh"

endmodule

`default_nettype wire

// File: verilog/dsp_lane.sv
`timescale 1ns/10ps
`default_nettype none

module dsp_lane
    import pe_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  lane_t      a,   // accumulator lane
    input  lane_t      b,   // operand lane, register or immediate
    input  slice_cfg_t cfg, // arrives two edges after the operands
    output lane_t      p    // lane result, six edges after capture
);

    ////////////////////
    // operand registers
    ////////////////////

    lane_t a1_q;
    lane_t b1_q;
    lane_t a1_dly_q;  // waits for the decoded cfg
    lane_t b1_dly_q;
    lane_t a2_q;
    lane_t b2_q;
    lane_t a1_p_q;    // A1 path towards the multiplier
    lane_t b1_p_q;

    always_ff @(posedge clk) begin
        a1_q     <= a;
        b1_q     <= b;
        a1_dly_q <= a1_q;
        b1_dly_q <= b1_q;
        a1_p_q   <= a1_dly_q;
        b1_p_q   <= b1_dly_q;
        if (cfg.cea2) begin
            a2_q <= a1_dly_q; // add/sub only
        end
        if (cfg.ceb2) begin
            b2_q <= b1_dly_q;
        end
    end

    ////////////////////
    // cfg pipeline
    ////////////////////

    slice_cfg_t cfg_e3_q; // drives the M / adder stage
    slice_cfg_t cfg_e4_q; // drives the P mux

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_e3_q <= cfg_load;
            cfg_e4_q <= cfg_load;
        end else begin
            cfg_e3_q <= cfg;
            cfg_e4_q <= cfg_e3_q;
        end
    end

    ////////////////////
    // multiply and add
    ////////////////////

    lane_t                   mul_a;
    lane_t                   mul_b;
    logic [2*lane_width-1:0] prod;   // full product, low byte kept
    lane_t                   sum;
    lane_t                   m_q;    // M register
    lane_t                   sum_q;  // adder stage
    lane_t                   pass_q; // A bypass for load

    // inmode picks A1/B1 or A2/B2 as multiplier inputs
    assign mul_a = (cfg_e3_q.inmode == inmode_a1b1) ? a1_p_q : a2_q;
    assign mul_b = (cfg_e3_q.inmode == inmode_a1b1) ? b1_p_q : b2_q;
    assign prod  = mul_a * mul_b;

    // wraps mod 256, no carry out of the lane
    assign sum = (cfg_e3_q.alumode == alumode_sub) ? a2_q - b2_q : a2_q + b2_q;

    always_ff @(posedge clk) begin
        if (cfg_e3_q.usemult) begin
            m_q <= prod[lane_width-1:0];
        end
        sum_q  <= sum;
        pass_q <= a1_p_q;
    end

    ////////////////////
    // P and output
    ////////////////////

    lane_t p_q;

    always_ff @(posedge clk) begin
        case (cfg_e4_q.opmode)
            opmode_addsub: begin
                p_q <= sum_q;
            end
            opmode_mul: begin
                p_q <= m_q;
            end
            default: begin
                p_q <= pass_q; // idle, A unchanged
            end
        endcase
        p <= p_q;              // output register
    end

endmodule

`default_nettype wire

// File: verilog/pe_top.sv
`timescale 1ns/10ps
`default_nettype none

module pe_top
    import pe_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     inst_v,   // instruction strobe
    input  pe_inst_u inst,
    input  logic     din_ld_v, // load strobe
    input  word_t    din_ld,
    output word_t    dout,     // accumulator
    output logic     dout_v    // write-back strobe
);

    slice_cfg_vec_t cfg;
    word_t          din_wb; // lanes back to the accumulator
    word_t          opnd_b; // operand B, all lanes

    ////////////////////
    // operand B select
    ////////////////////

    // immediate byte goes to every lane
    assign opnd_b = inst.imm_view.opcode[op_width-1] ? {num_lanes{inst.imm_view.imm}}
                                                     : inst.reg_view.operand;

    ////////////////////
    // control
    ////////////////////

    pe_control u_control (
        .clk      (clk),
        .arst_n   (arst_n),
        .inst_v   (inst_v),
        .inst     (inst),
        .din_ld_v (din_ld_v),
        .din_ld   (din_ld),
        .din_wb   (din_wb),
        .cfg      (cfg),
        .dout     (dout),
        .dout_v   (dout_v)
    );

    ////////////////////
    // lanes
    ////////////////////

    // accumulator feeds back as operand A
    for (genvar g = 0; g < num_lanes; g++) begin : g_lane
        dsp_lane u_lane (
            .clk    (clk),
            .arst_n (arst_n),
            .a      (dout[g*lane_width +: lane_width]),
            .b      (opnd_b[g*lane_width +: lane_width]),
            .cfg    (cfg[g]),
            .p      (din_wb[g*lane_width +: lane_width])
        );
    end

endmodule

`default_nettype wire
